// File: Bender.yml
package:
  name: rv32i_pipeline

sources:
  - files:
      - common/cpu_pkg.sv
      - logic/sync_ram.sv
      - decode/decoder.sv
      - decode/register_file.sv
      - execute/execute_unit.sv
      - logic/hazard_unit.sv
      - logic/pipeline_core.sv
      - logic/run_monitor.sv
      - logic/cpu_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_cpu.sv

// File: common/cpu_pkg.sv
package cpu_pkg;

  localparam int xlen        = 32;
  localparam int reg_addr_w  = 5;
  localparam int imem_addr_w = 10;   // Word address, 4 KiB
  localparam int dmem_addr_w = 10;

  // RV32I major opcodes
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

  typedef enum logic [3:0] {
    ic_nop, ic_alu_reg, ic_alu_imm, ic_lui, ic_load, ic_store, ic_branch, ic_jal
  } iclass_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sll, alu_srl
  } alu_op_t;

  typedef enum logic [1:0] {br_beq, br_bne, br_blt} br_op_t;

  // Operand source at the execute input
  typedef enum logic [1:0] {fwd_reg, fwd_wb, fwd_mem} fwd_t;

  typedef struct packed {
    iclass_t               iclass;
    alu_op_t               alu_op;
    br_op_t                br_op;
    logic [reg_addr_w-1:0] rs1;    // Zero when not read
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;     // Zero when not written
    logic [xlen-1:0]       imm;    // Sign extended
  } dec_instr_t;

  typedef struct packed {
    dec_instr_t      dec;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rval1;
    logic [xlen-1:0] rval2;
  } ex_stage_t;

  typedef struct packed {
    iclass_t               iclass;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       result;
    logic [xlen-1:0]       addr;   // Byte address for LW/SW
    logic [xlen-1:0]       sdata;
  } mem_stage_t;

  typedef struct packed {
    iclass_t               iclass;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       result;
  } wb_stage_t;

  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
  } retire_t;

  // Classes that write rd
  function automatic logic writes_rd(iclass_t c);
    return c inside {ic_alu_reg, ic_alu_imm, ic_lui, ic_load, ic_jal};
  endfunction

endpackage

// File: decode/decoder.sv
`timescale 1ns/1ns

module decoder
  import cpu_pkg::*;
(
  input  logic [xlen-1:0] instr,
  output dec_instr_t      dec
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Immediate formats
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec     = '0;
    dec.rs1 = instr[19:15];
    dec.rs2 = instr[24:20];
    dec.rd  = instr[11:7];
    case (opcode)
      op_reg: begin
        dec.iclass = ic_alu_reg;
        case ({funct7, funct3})
          {7'h00, 3'b000}: dec.alu_op = alu_add;
          {7'h20, 3'b000}: dec.alu_op = alu_sub;
          {7'h00, 3'b001}: dec.alu_op = alu_sll;
          {7'h00, 3'b010}: dec.alu_op = alu_slt;
          {7'h00, 3'b100}: dec.alu_op = alu_xor;
          {7'h00, 3'b101}: dec.alu_op = alu_srl;
          {7'h00, 3'b110}: dec.alu_op = alu_or;
          {7'h00, 3'b111}: dec.alu_op = alu_and;
          default:         dec.iclass = ic_nop;   // SRA and friends not supported
        endcase
      end
      op_imm: begin
        dec.iclass = ic_alu_imm;
        dec.rs2    = '0;
        dec.imm    = imm_i;
        case (funct3)
          3'b000:  dec.alu_op = alu_add;
          3'b010:  dec.alu_op = alu_slt;
          3'b100:  dec.alu_op = alu_xor;
          3'b110:  dec.alu_op = alu_or;
          3'b111:  dec.alu_op = alu_and;
          default: dec.iclass = ic_nop;   // No immediate shifts
        endcase
      end
      op_lui: begin
        dec.iclass = ic_lui;
        dec.rs1    = '0;
        dec.rs2    = '0;
        dec.imm    = imm_u;
      end
      op_load: begin
        dec.iclass = (funct3 == 3'b010) ? ic_load : ic_nop;   // LW only
        dec.rs2    = '0;
        dec.imm    = imm_i;
      end
      op_store: begin
        dec.iclass = (funct3 == 3'b010) ? ic_store : ic_nop;  // SW only
        dec.rd     = '0;
        dec.imm    = imm_s;
      end
      op_branch: begin
        dec.iclass = ic_branch;
        dec.rd     = '0;
        dec.imm    = imm_b;
        case (funct3)
          3'b000:  dec.br_op = br_beq;
          3'b001:  dec.br_op = br_bne;
          3'b100:  dec.br_op = br_blt;
          default: dec.iclass = ic_nop;
        endcase
      end
      op_jal: begin
        dec.iclass = ic_jal;
        dec.rs1    = '0;
        dec.rs2    = '0;
        dec.imm    = imm_j;
      end
      default: ;
    endcase
    // Zero word and anything unknown become a clean bubble
    if (dec.iclass == ic_nop) begin
      dec = '0;
    end
  end

endmodule

// File: decode/register_file.sv
`timescale 1ns/1ns

module register_file
  import cpu_pkg::*;
(
  input  logic                  clk_100mhz,
  input  logic                  sys_rst,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  input  logic [reg_addr_w-1:0] wa,
  input  logic                  we,
  input  logic [xlen-1:0]       wd,
  output logic [xlen-1:0]       rd1,
  output logic [xlen-1:0]       rd2
);

  logic [xlen-1:0] regs [2**reg_addr_w];
  logic            wr_live;   // Write this cycle to a real register

  assign wr_live = we && (wa != '0);

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wa] <= wd;   // x0 never written
    end
  end

  // Write-through so decode sees the value retiring this cycle
  assign rd1 = (wr_live && wa == rs1) ? wd : regs[rs1];
  assign rd2 = (wr_live && wa == rs2) ? wd : regs[rs2];

endmodule

// File: execute/execute_unit.sv
`timescale 1ns/1ns

module execute_unit
  import cpu_pkg::*;
(
  input  ex_stage_t       ex,        // Operands already forwarded
  output logic [xlen-1:0] result,
  output logic [xlen-1:0] addr,
  output logic [xlen-1:0] next_pc,
  output logic            redirect
);

  logic [xlen-1:0] opb;
  logic [xlen-1:0] alu_out;
  logic [xlen-1:0] pc_plus4;
  logic            taken;

  assign opb      = (ex.dec.iclass == ic_alu_reg) ? ex.rval2 : ex.dec.imm;
  assign pc_plus4 = ex.pc + xlen'(4);

  always_comb begin
    case (ex.dec.alu_op)
      alu_sub: alu_out = ex.rval1 - opb;
      alu_and: alu_out = ex.rval1 & opb;
      alu_or:  alu_out = ex.rval1 | opb;
      alu_xor: alu_out = ex.rval1 ^ opb;
      alu_slt: alu_out = xlen'($signed(ex.rval1) < $signed(opb));
      alu_sll: alu_out = ex.rval1 << opb[4:0];
      alu_srl: alu_out = ex.rval1 >> opb[4:0];
      default: alu_out = ex.rval1 + opb;   // ADD, ADDI
    endcase
  end

  // Branch compare always on the two registers
  always_comb begin
    case (ex.dec.br_op)
      br_bne:  taken = ex.rval1 != ex.rval2;
      br_blt:  taken = $signed(ex.rval1) < $signed(ex.rval2);
      default: taken = ex.rval1 == ex.rval2;
    endcase
  end

  always_comb begin
    case (ex.dec.iclass)
      ic_lui:  result = ex.dec.imm;
      ic_jal:  result = pc_plus4;   // Link value
      default: result = alu_out;
    endcase
  end

  assign addr = ex.rval1 + ex.dec.imm;   // LW/SW byte address

  always_comb begin
    if (ex.dec.iclass == ic_jal || (ex.dec.iclass == ic_branch && taken)) begin
      next_pc = ex.pc + ex.dec.imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  // A jump to pc+4 needs no flush
  assign redirect = next_pc != pc_plus4;

endmodule

// File: list.f
+incdir+sim
common/cpu_pkg.sv
logic/sync_ram.sv
decode/decoder.sv
decode/register_file.sv
execute/execute_unit.sv
logic/hazard_unit.sv
logic/pipeline_core.sv
logic/run_monitor.sv
logic/cpu_top.sv
sim/tb_cpu.sv

// File: logic/cpu_top.sv
`timescale 1ns/1ns

module cpu_top
  import cpu_pkg::*;
(
  input  logic                   clk_100mhz,
  input  logic                   sys_rst,
  input  logic                   prog_we,
  input  logic [imem_addr_w-1:0] prog_addr,
  input  logic [xlen-1:0]        prog_data,
  output logic                   retire_valid,
  output retire_t                retire,
  output logic                   halted,
  output logic [xlen-1:0]        cycle_count
);

  logic [imem_addr_w-1:0] core_imem_addr, imem_addr;
  logic [xlen-1:0]        imem_rdata, dmem_rdata, dmem_wdata;
  logic [dmem_addr_w-1:0] dmem_addr;
  logic                   imem_we, dmem_we;
  logic                   fetch_zero, drained, halt_req;

  // Loader owns imem while the core sits in reset
  assign imem_we   = sys_rst && prog_we;
  assign imem_addr = sys_rst ? prog_addr : core_imem_addr;

  sync_ram #(.addr_w(imem_addr_w)) u_imem (
    .clk_100mhz, .we(imem_we), .addr(imem_addr), .wdata(prog_data), .rdata(imem_rdata)
  );

  sync_ram #(.addr_w(dmem_addr_w)) u_dmem (
    .clk_100mhz, .we(dmem_we), .addr(dmem_addr), .wdata(dmem_wdata), .rdata(dmem_rdata)
  );

  pipeline_core u_core (
    .clk_100mhz, .sys_rst, .imem_rdata, .dmem_rdata, .halt_req,
    .imem_addr(core_imem_addr), .dmem_addr, .dmem_we, .dmem_wdata,
    .retire_valid, .retire, .fetch_zero, .drained
  );

  run_monitor u_monitor (
    .clk_100mhz, .sys_rst, .fetch_zero, .drained, .halt_req, .halted, .cycle_count
  );

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit
  import cpu_pkg::*;
(
  input  dec_instr_t dec,   // Instruction in decode
  input  ex_stage_t  ex,
  input  mem_stage_t mem,
  input  wb_stage_t  wb,
  input  logic       redirect,
  output logic       stall,
  output logic       flush,
  output fwd_t       fwd1,
  output fwd_t       fwd2
);

  logic mem_fwd_ok;
  logic wb_fwd_ok;

  // Load in MEM has no data yet, load-use stall keeps it from being needed
  assign mem_fwd_ok = writes_rd(mem.iclass) && mem.iclass != ic_load && mem.rd != '0;
  assign wb_fwd_ok  = writes_rd(wb.iclass) && wb.rd != '0;

  // Load-use, rs fields are zero when unused so no false stalls
  assign stall = ex.dec.iclass == ic_load && ex.dec.rd != '0
                 && (ex.dec.rd == dec.rs1 || ex.dec.rd == dec.rs2);

  assign flush = redirect;   // Drops IF/ID and the word being fetched

  // MEM is the younger producer so it wins
  always_comb begin
    fwd1 = fwd_reg;
    if (mem_fwd_ok && mem.rd == ex.dec.rs1) begin
      fwd1 = fwd_mem;
    end else if (wb_fwd_ok && wb.rd == ex.dec.rs1) begin
      fwd1 = fwd_wb;
    end
  end

  always_comb begin
    fwd2 = fwd_reg;
    if (mem_fwd_ok && mem.rd == ex.dec.rs2) begin
      fwd2 = fwd_mem;
    end else if (wb_fwd_ok && wb.rd == ex.dec.rs2) begin
      fwd2 = fwd_wb;
    end
  end

  // Execute only redirects on branch or JAL, never while a load sits there
  always_comb begin
    a_no_stall_on_flush : assert #0 (!(stall === 1'b1 && flush === 1'b1))
      else $error("hazard_unit load stall together with a redirect");
  end

endmodule

// File: logic/pipeline_core.sv
`timescale 1ns/1ns

module pipeline_core
  import cpu_pkg::*;
(
  input  logic                   clk_100mhz,
  input  logic                   sys_rst,
  input  logic [xlen-1:0]        imem_rdata,
  input  logic [xlen-1:0]        dmem_rdata,
  input  logic                   halt_req,
  output logic [imem_addr_w-1:0] imem_addr,
  output logic [dmem_addr_w-1:0] dmem_addr,
  output logic                   dmem_we,
  output logic [xlen-1:0]        dmem_wdata,
  output logic                   retire_valid,
  output retire_t                retire,
  output logic                   fetch_zero,
  output logic                   drained
);

  logic [xlen-1:0] pc;         // Address sent to imem
  logic [xlen-1:0] id_pc;      // Address of the word now in decode
  logic            id_valid;
  logic [xlen-1:0] id_instr;
  dec_instr_t      id_dec;
  logic [xlen-1:0] rd1, rd2;
  ex_stage_t       ex_q, ex_fwd;
  mem_stage_t      mem_q;
  wb_stage_t       wb_q;
  logic [xlen-1:0] ex_result, ex_addr, ex_next_pc, wb_data;
  logic            redirect, stall, flush, hold, wb_we;
  fwd_t            fwd1, fwd2;

  assign hold = stall || halt_req;   // Freeze PC and IF/ID
  // Re-read the decode word while frozen so imem output holds
  assign imem_addr = hold ? id_pc[imem_addr_w+1:2] : pc[imem_addr_w+1:2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      pc       <= '0;
      id_pc    <= '0;
      id_valid <= 1'b0;
    end else if (flush) begin
      pc       <= ex_next_pc;   // Target fetched next cycle
      id_valid <= 1'b0;         // Kill word in flight
    end else if (!hold) begin
      id_pc    <= pc;
      id_valid <= 1'b1;
      pc       <= pc + xlen'(4);
    end
  end

  assign id_instr   = id_valid ? imem_rdata : '0;
  assign fetch_zero = id_valid && imem_rdata == '0 && !redirect;   // Not on a dead path

  decoder u_decoder (.instr(id_instr), .dec(id_dec));

  register_file u_regs (
    .clk_100mhz, .sys_rst,
    .rs1(id_dec.rs1), .rs2(id_dec.rs2),
    .wa(wb_q.rd), .we(wb_we), .wd(wb_data),
    .rd1, .rd2
  );

  hazard_unit u_hazard (
    .dec(id_dec), .ex(ex_q), .mem(mem_q), .wb(wb_q), .redirect,
    .stall, .flush, .fwd1, .fwd2
  );

  // ID/EX, bubble on stall or flush
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst || flush || stall) begin
      ex_q <= '0;
    end else begin
      ex_q <= '{dec: id_dec, pc: id_pc, rval1: rd1, rval2: rd2};
    end
  end

  // Operand bypass at the execute input
  always_comb begin
    ex_fwd = ex_q;
    case (fwd1)
      fwd_mem: ex_fwd.rval1 = mem_q.result;
      fwd_wb:  ex_fwd.rval1 = wb_data;
      default: ;
    endcase
    case (fwd2)
      fwd_mem: ex_fwd.rval2 = mem_q.result;
      fwd_wb:  ex_fwd.rval2 = wb_data;
      default: ;
    endcase
  end

  execute_unit u_execute (
    .ex(ex_fwd), .result(ex_result), .addr(ex_addr), .next_pc(ex_next_pc), .redirect
  );

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      mem_q <= '0;
      wb_q  <= '0;
    end else begin
      mem_q <= '{iclass: ex_fwd.dec.iclass, rd: ex_fwd.dec.rd, result: ex_result,
                 addr: ex_addr, sdata: ex_fwd.rval2};
      wb_q  <= '{iclass: mem_q.iclass, rd: mem_q.rd, result: mem_q.result};
    end
  end

  // Store lands at the edge closing MEM
  assign dmem_addr  = mem_q.addr[dmem_addr_w+1:2];
  assign dmem_we    = mem_q.iclass == ic_store;
  assign dmem_wdata = mem_q.sdata;

  assign wb_data      = (wb_q.iclass == ic_load) ? dmem_rdata : wb_q.result;
  assign wb_we        = writes_rd(wb_q.iclass) && wb_q.rd != '0;
  assign retire_valid = wb_we;   // Same strobe as the register write
  assign retire       = '{rd: wb_q.rd, data: wb_data};

  assign drained = ex_q.dec.iclass == ic_nop && mem_q.iclass == ic_nop
                   && wb_q.iclass == ic_nop;

endmodule

// File: logic/run_monitor.sv
`timescale 1ns/1ns

module run_monitor
  import cpu_pkg::*;
(
  input  logic            clk_100mhz,
  input  logic            sys_rst,
  input  logic            fetch_zero,
  input  logic            drained,
  output logic            halt_req,
  output logic            halted,
  output logic [xlen-1:0] cycle_count
);

  typedef enum logic {st_run, st_halt} state_t;

  state_t state;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state       <= st_run;
      cycle_count <= '0;
    end else if (state == st_run) begin
      cycle_count <= cycle_count + 1'b1;   // Frozen once halted
      if (fetch_zero && drained) begin
        state <= st_halt;                  // Last retire has gone
      end
    end
  end

  assign halted   = state == st_halt;
  assign halt_req = fetch_zero || halted;   // Stop fetch as soon as the zero word shows

  // Frozen fetch keeps later stages empty until reset
  a_halt_drained : assert property (
    @(posedge clk_100mhz) disable iff (sys_rst) halted |-> drained
  ) else $error("run_monitor pipeline not empty while halted");

endmodule

// File: logic/sync_ram.sv
`timescale 1ns/1ns

module sync_ram
  import cpu_pkg::*;
#(
  parameter int addr_w = 10
) (
  input  logic              clk_100mhz,
  input  logic              we,
  input  logic [addr_w-1:0] addr,
  input  logic [xlen-1:0]   wdata,
  output logic [xlen-1:0]   rdata
);

  logic [xlen-1:0] mem [2**addr_w];

  // Write first, new data shows on the read port
  always_ff @(posedge clk_100mhz) begin
    if (we) begin
      mem[addr] <= wdata;
      rdata     <= wdata;
    end else begin
      rdata <= mem[addr];   // One cycle read latency
    end
  end

  // Stray writes would corrupt the program or data image
  a_write_addr_known : assert property (
    @(posedge clk_100mhz) we |-> !$isunknown(addr)
  ) else $error("sync_ram write with unknown address");

endmodule

// File: sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Abstract instruction as the generator builds it, before encoding
typedef enum logic [4:0] {
  i_add, i_sub, i_and, i_or, i_xor, i_slt, i_sll, i_srl,
  i_addi, i_andi, i_ori, i_xori, i_slti, i_lui,
  i_lw, i_sw, i_beq, i_bne, i_blt, i_jal
} kind_t;

typedef struct packed {
  kind_t       kind;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] imm;   // Byte offset for branches and JAL
} instr_t;

instr_t      prog[$];              // Program up to, not including, the zero word
retire_t     expected[$];          // Register writes in program order
int          exec_count;           // Instructions actually executed
logic [31:0] model_regs[32];
logic [31:0] model_mem[1024];      // Survives reset like the real data memory

// RV32I field layout per format
function automatic logic [31:0] encode(instr_t ins);
  logic [31:0] im;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  im  = ins.imm;
  rd  = ins.rd;
  rs1 = ins.rs1;
  rs2 = ins.rs2;
  case (ins.kind)
    i_add:  return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
    i_sub:  return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
    i_and:  return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
    i_or:   return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
    i_xor:  return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
    i_slt:  return {7'h00, rs2, rs1, 3'b010, rd, 7'b0110011};
    i_sll:  return {7'h00, rs2, rs1, 3'b001, rd, 7'b0110011};
    i_srl:  return {7'h00, rs2, rs1, 3'b101, rd, 7'b0110011};
    i_addi: return {im[11:0], rs1, 3'b000, rd, 7'b0010011};
    i_andi: return {im[11:0], rs1, 3'b111, rd, 7'b0010011};
    i_ori:  return {im[11:0], rs1, 3'b110, rd, 7'b0010011};
    i_xori: return {im[11:0], rs1, 3'b100, rd, 7'b0010011};
    i_slti: return {im[11:0], rs1, 3'b010, rd, 7'b0010011};
    i_lui:  return {im[31:12], rd, 7'b0110111};
    i_lw:   return {im[11:0], rs1, 3'b010, rd, 7'b0000011};
    i_sw:   return {im[11:5], rs2, rs1, 3'b010, im[4:0], 7'b0100011};
    i_beq:  return {im[12], im[10:5], rs2, rs1, 3'b000, im[4:1], im[11], 7'b1100011};
    i_bne:  return {im[12], im[10:5], rs2, rs1, 3'b001, im[4:1], im[11], 7'b1100011};
    i_blt:  return {im[12], im[10:5], rs2, rs1, 3'b100, im[4:1], im[11], 7'b1100011};
    default: return {im[20], im[10:1], im[11], im[19:12], rd, 7'b1101111};   // JAL
  endcase
endfunction

// Instruction-level execution, one instruction at a time
function automatic void run_model();
  int          pc;     // Instruction index
  int          next;
  instr_t      ins;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] ea;
  logic [31:0] res;
  logic        wr;
  expected.delete();
  exec_count = 0;
  foreach (model_regs[r]) begin
    model_regs[r] = '0;   // Fresh state after reset
  end
  pc = 0;
  while (pc < prog.size()) begin
    ins  = prog[pc];
    a    = model_regs[ins.rs1];
    b    = model_regs[ins.rs2];
    ea   = a + ins.imm;
    next = pc + 1;
    wr   = 1'b1;
    res  = '0;
    case (ins.kind)
      i_add:  res = a + b;
      i_sub:  res = a - b;
      i_and:  res = a & b;
      i_or:   res = a | b;
      i_xor:  res = a ^ b;
      i_slt:  res = {31'b0, $signed(a) < $signed(b)};
      i_sll:  res = a << b[4:0];
      i_srl:  res = a >> b[4:0];
      i_addi: res = a + ins.imm;
      i_andi: res = a & ins.imm;
      i_ori:  res = a | ins.imm;
      i_xori: res = a ^ ins.imm;
      i_slti: res = {31'b0, $signed(a) < $signed(ins.imm)};
      i_lui:  res = ins.imm;
      i_lw:   res = model_mem[ea[11:2]];
      i_sw: begin
        model_mem[ea[11:2]] = b;
        wr = 1'b0;
      end
      i_beq, i_bne, i_blt: begin
        wr = 1'b0;
        if ((ins.kind == i_beq && a == b) || (ins.kind == i_bne && a != b)
            || (ins.kind == i_blt && $signed(a) < $signed(b))) begin
          next = pc + int'(ins.imm >> 2);
        end
      end
      i_jal: begin
        res  = 32'(4 * pc + 4);   // Link
        next = pc + int'(ins.imm >> 2);
      end
      default: wr = 1'b0;
    endcase
    if (wr && ins.rd != 5'd0) begin   // x0 stays zero, no retire
      model_regs[ins.rd] = res;
      expected.push_back('{rd: ins.rd, data: res});
    end
    exec_count++;
    pc = next;
  end
endfunction

`endif

// File: sim/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu
  import cpu_pkg::*;
();

  logic                   clk_100mhz = 1'b0;
  logic                   sys_rst;
  logic                   prog_we;
  logic [imem_addr_w-1:0] prog_addr;
  logic [xlen-1:0]        prog_data;
  logic                   retire_valid;
  retire_t                retire;
  logic                   halted;
  logic [xlen-1:0]        cycle_count;

  logic [31:0]     rng_state = 32'd85;
  logic [xlen-1:0] words[$];          // Encoded image with trailing zero word
  int              error_count = 0;
  int              test_count = 0;
  int              fail_count = 0;
  int              retire_idx;
  int              watchdog_budget = 0;   // Grows by each test's share
  int              cycles_run;

  `include "tb_model.svh"

  always #5 clk_100mhz = ~clk_100mhz;

  cpu_top UUT (.*);

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_below(int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:8] % n);   // Upper bits, low LCG bits are weak
  endfunction

  // mix 0 ALU, 1 memory, 2 control flow, 3 x0 heavy, 4 everything
  function automatic instr_t rand_instr(int mix, int last_rd);
    instr_t ins;
    int     pick;
    ins.kind = kind_t'(rand_below(14));                      // ALU or LUI
    ins.rd   = 5'(rand_below(16));
    ins.rs1  = (rand_below(2) == 0) ? 5'(last_rd) : 5'(rand_below(16));   // Chains
    ins.rs2  = 5'(rand_below(16));
    ins.imm  = 32'(rand_below(4096) - 2048);
    if (mix == 3 && rand_below(5) < 2) begin
      ins.rd  = 5'd0;
      ins.rs2 = 5'd0;
    end
    if (ins.kind == i_lui) begin
      ins.imm = next_rand() & 32'hFFFF_F000;
    end
    pick = rand_below(10);
    if ((mix == 1 || mix == 4) && pick < 3) begin
      ins.kind = (pick == 0) ? i_sw : i_lw;
      ins.rs1  = 5'd0;
      ins.imm  = 32'(4 * rand_below(8));   // One of the seeded words
    end else if ((mix == 2 || mix == 4) && pick >= 7) begin
      ins.kind = kind_t'(i_beq + rand_below(4));
      if (rand_below(3) == 0) begin
        ins.rs2 = ins.rs1;   // More taken BEQ
      end
      ins.imm = 32'(1 + rand_below(5));   // Distance in words for now
    end
    return ins;
  endfunction

  task automatic build_program(input int mix, input int body_len, input bit seed_regs);
    instr_t ins;
    int     last_rd;
    int     d;
    prog.delete();
    words.delete();
    if (seed_regs) begin   // Reset zeros stay visible when not seeded
      for (int r = 1; r < 16; r++) begin
        prog.push_back('{kind: i_addi, rd: 5'(r), rs1: 5'd0, rs2: 5'd0,
                         imm: 32'(rand_below(4096) - 2048)});
      end
    end
    if (mix == 1 || mix == 4) begin   // Store first so every load hits written data
      for (int k = 0; k < 8; k++) begin
        prog.push_back('{kind: i_sw, rd: 5'd0, rs1: 5'd0, rs2: 5'(k + 1), imm: 32'(4 * k)});
      end
    end
    last_rd = 15;
    for (int i = 0; i < body_len; i++) begin
      ins = rand_instr(mix, last_rd);
      prog.push_back(ins);
      if (ins.kind == i_lw) begin   // Load-use partner
        prog.push_back('{kind: i_add, rd: 5'(rand_below(15) + 1), rs1: ins.rd,
                         rs2: ins.rd, imm: '0});
      end
      last_rd = ins.rd;
    end
    foreach (prog[i]) begin
      ins = prog[i];
      if (ins.kind inside {i_beq, i_bne, i_blt, i_jal}) begin
        d = int'(ins.imm);
        if (d > prog.size() - i) begin
          d = prog.size() - i;   // Land no further than the zero word
        end
        ins.imm = 32'(4 * d);
        prog[i] = ins;
      end
      words.push_back(encode(prog[i]));
    end
    words.push_back('0);
  endtask

  // Core held in reset while the image goes in, at least 16 cycles
  task automatic load_program();
    int n;
    @(negedge clk_100mhz);
    sys_rst = 1'b1;
    n = 0;
    foreach (words[i]) begin
      prog_we   = 1'b1;
      prog_addr = imem_addr_w'(i);
      prog_data = words[i];
      @(negedge clk_100mhz);
      n++;
    end
    prog_we = 1'b0;
    while (n < 16) begin
      @(negedge clk_100mhz);
      n++;
    end
    sys_rst = 1'b0;
  endtask

  task automatic check_retire(input retire_t got);
    if (retire_idx >= expected.size()) begin
      $display("Unexpected extra retire of x%0d = %h at %0t", got.rd, got.data, $time);
      error_count++;
    end else if (got !== expected[retire_idx]) begin
      $display("Fail at %0t: retire %0d is x%0d = %h, expected x%0d = %h", $time,
               retire_idx, got.rd, got.data, expected[retire_idx].rd, expected[retire_idx].data);
      error_count++;
    end
    retire_idx++;
  endtask

  task automatic check_status(input logic got_halted, input logic [xlen-1:0] got_count,
                              input logic [xlen-1:0] lo, input logic [xlen-1:0] hi);
    if (got_halted !== 1'b1) begin
      $display("Fail at %0t: halted is %b, expected 1", $time, got_halted);
      error_count++;
    end
    if ($isunknown(got_count) || got_count < lo || got_count > hi) begin
      $display("Fail at %0t: cycle_count %0d outside %0d..%0d", $time, got_count, lo, hi);
      error_count++;
    end
  endtask

  task automatic run_test(input string name, input int mix, input int body_len,
                          input bit seed_regs);
    int              errs_before;
    logic [xlen-1:0] frozen;
    errs_before = error_count;
    build_program(mix, body_len, seed_regs);
    run_model();
    watchdog_budget += 40 * words.size() + 200;
    load_program();
    retire_idx = 0;
    do begin   // Outputs move on posedge, sampled half a cycle later
      @(negedge clk_100mhz);
      if (retire_valid) begin
        check_retire(retire);
      end
    end while (!halted);
    if (retire_idx < expected.size()) begin
      $display("Missing retires, %0d seen of %0d", retire_idx, expected.size());
      error_count++;
    end
    check_status(halted, cycle_count, xlen'(exec_count + 4), '1);
    frozen = cycle_count;
    repeat (8) begin   // Halt is sticky, counter frozen, no late retire
      @(negedge clk_100mhz);
      if (retire_valid) begin
        $display("Retire seen while halted at %0t", $time);
        error_count++;
      end
      check_status(halted, cycle_count, frozen, frozen);
    end
    test_count++;
    if (error_count != errs_before) begin
      fail_count++;
    end
    $display("Test %s: %s, %0d executed, %0d retires, %0d cycles", name,
             (error_count == errs_before) ? "ok" : "FAILED", exec_count, retire_idx, frozen);
  endtask

  initial begin
    sys_rst   = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    run_test("alu_forwarding", 0, 48, 1'b1);
    run_test("load_store", 1, 40, 1'b1);
    run_test("branch_jal", 2, 48, 1'b1);
    run_test("x0_writes", 3, 40, 1'b1);
    run_test("mixed", 4, 60, 1'b1);
    run_test("mixed_after_reset", 4, 60, 1'b0);   // Fresh register state again
    $display("Tests %0d, failed %0d, errors %0d", test_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Budget checked every cycle, it grows as tests start
  initial begin
    cycles_run = 0;
    do begin
      @(posedge clk_100mhz);
      cycles_run++;
    end while (cycles_run <= watchdog_budget);
    $display("Watchdog expired after %0d cycles, the core never halted", cycles_run);
    $display("Regression failed");
    $finish;
  end

endmodule
